/* common/ialu_cfg_pkg.sv */
/* ALU configuration constants
   Word width, multiplier chunk size and the fixed registers around the stage chain */
package ialu_cfg_pkg;

    // ------------------------------------------------------------------
    // Datapath sizing
    // ------------------------------------------------------------------

    localparam int XLEN_DEFAULT   = 32;   // Data word width
    localparam int CHUNK_DEFAULT  = 8;    // Multiplier bits per stage

    // ------------------------------------------------------------------
    // Pipeline depth
    // ------------------------------------------------------------------

    // Issue register plus output register
    // Full latency is this plus XLEN/CHUNK stages
    localparam int RETIRE_LATENCY = 2;

endpackage

/* common/ialu_cmd_pkg.sv */
/* ALU command encoding
   Raw 5-bit codes, the group/variant field view and the variant bit positions */
package ialu_cmd_pkg;

    // Shift amount taken from op2
    localparam int SHAMT_W = 5;

    // ------------------------------------------------------------------
    // Command groups
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        GRP_ALU = 2'b00,   // Add, sub, bitwise logic
        GRP_CMP = 2'b01,   // Set-less-than and branch compares
        GRP_SHF = 2'b10,   // Shifts
        GRP_MUL = 2'b11    // Multiplier chain
    } ialu_grp_e;

    // Variant bits, multiply group
    localparam int VAR_HI    = 2;   // High half requested
    localparam int VAR_S1    = 1;   // Operand 1 signed
    localparam int VAR_S2    = 0;   // Operand 2 signed

    // Variant bits, compare group
    localparam int VAR_SGN   = 2;   // Signed compare
    localparam int VAR_INV   = 1;   // Invert the flag
    localparam int VAR_EQ    = 0;   // Equality instead of less-than

    // Variant bits, shift group
    localparam int VAR_RIGHT = 1;   // Right shift
    localparam int VAR_ARITH = 0;   // Sign fill on right shift

    typedef struct packed {
        ialu_grp_e  grp;
        logic [2:0] variant;
    } ialu_cmd_fields_s;

    // Same 5 bits, seen as raw code or as fields
    typedef union packed {
        logic [4:0]       raw;
        ialu_cmd_fields_s fields;
    } ialu_cmd_u;

    // ------------------------------------------------------------------
    // Raw command codes, {grp, variant}
    // ------------------------------------------------------------------

    typedef enum logic [4:0] {
        CMD_ADD    = 5'h00,
        CMD_SUB    = 5'h01,
        CMD_AND    = 5'h02,
        CMD_OR     = 5'h03,
        CMD_XOR    = 5'h04,
        CMD_LTU    = 5'h08,   // unsigned, no invert
        CMD_EQ     = 5'h09,
        CMD_GEU    = 5'h0A,
        CMD_NE     = 5'h0B,
        CMD_LT     = 5'h0C,   // signed
        CMD_GE     = 5'h0E,
        CMD_SLL    = 5'h10,
        CMD_SRL    = 5'h12,
        CMD_SRA    = 5'h13,
        CMD_MUL    = 5'h1B,   // low half, sign bits set for the negate path
        CMD_MULHU  = 5'h1C,
        CMD_MULHSU = 5'h1E,
        CMD_MULH   = 5'h1F
    } ialu_cmd_e;

endpackage

/* common/mul_stage_if.sv */
/* Link between ALU pipeline stages
   Carries one in-flight operation forward and the stall control backward */
`timescale 1ns/100ps

interface mul_stage_if #(
    parameter int XLEN = ialu_cfg_pkg::XLEN_DEFAULT
);
    import ialu_cmd_pkg::*;

    logic              valid;     // Stage holds an operation
    ialu_cmd_u         cmd;
    logic [XLEN-1:0]   mcand;     // Multiplicand magnitude
    logic [XLEN-1:0]   mplier;    // Multiplier bits still to consume
    logic [2*XLEN-1:0] acc;       // Partial product so far
    logic              neg;       // Negate product at retire
    logic [XLEN-1:0]   res;       // Finished non-multiply result
    logic              flag;      // Compare result
    logic              advance;   // Whole chain moves this cycle

    // Upstream side
    modport src (
        output valid, cmd, mcand, mplier, acc, neg, res, flag,
        input  advance
    );

    // Downstream side
    modport dst (
        input  valid, cmd, mcand, mplier, acc, neg, res, flag,
        output advance
    );

endinterface

/* exec/ialu_issue.sv */
/* ALU issue stage
   Registers the command, computes add/compare/logic/shift and prepares multiply operands */
`timescale 1ns/100ps

module ialu_issue #(
    parameter int XLEN = ialu_cfg_pkg::XLEN_DEFAULT
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    input  ialu_cmd_pkg::ialu_cmd_u cmd_i,
    input  logic [XLEN-1:0]         op1_i,
    input  logic [XLEN-1:0]         op2_i,
    output logic                    ready_o,
    mul_stage_if.src                out
);
    import ialu_cmd_pkg::*;

    // Input register
    logic                valid_q;
    ialu_cmd_u           cmd_q;
    logic [XLEN-1:0]     op1_q;
    logic [XLEN-1:0]     op2_q;

    // Main adder
    logic                sub;
    logic [XLEN:0]       sum;        // MSB is carry / borrow
    logic                flag_z;
    logic                flag_s;
    logic                flag_o;
    logic                flag_c;

    logic                cmp_flag;
    logic [XLEN-1:0]     alu_res;
    logic [SHAMT_W-1:0]  shamt;
    logic [XLEN-1:0]     shf_res;
    logic [XLEN-1:0]     res;

    // Multiply operand prep
    logic                is_mul;
    logic                op1_neg;    // op1 treated signed and negative
    logic                op2_neg;

    assign ready_o = out.advance;    // Chain stalled, input stalled

    // ------------------------------------------------------------------
    // Input register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (out.advance) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i && ready_o) begin
            cmd_q <= cmd_i;
            op1_q <= op1_i;
            op2_q <= op2_i;
        end
    end

    // ------------------------------------------------------------------
    // Main adder and flags
    // ------------------------------------------------------------------

    always_comb begin
        sub    = (cmd_q.raw != CMD_ADD);   // compares use the difference too
        sum    = sub ? ({1'b0, op1_q} - {1'b0, op2_q})
                     : ({1'b0, op1_q} + {1'b0, op2_q});
        flag_c = sum[XLEN];                // Borrow on subtract
        flag_z = ~|sum[XLEN-1:0];
        flag_s = sum[XLEN-1];
        // Overflow, operand signs vs result sign
        flag_o = sub ? ((op1_q[XLEN-1] ^ op2_q[XLEN-1]) & (flag_s ^ op1_q[XLEN-1]))
                     : (~(op1_q[XLEN-1] ^ op2_q[XLEN-1]) & (flag_s ^ op1_q[XLEN-1]));
    end

    // Equality, signed or unsigned less-than, then optional invert
    always_comb begin
        if (cmd_q.fields.variant[VAR_EQ]) begin
            cmp_flag = flag_z;
        end else if (cmd_q.fields.variant[VAR_SGN]) begin
            cmp_flag = flag_s ^ flag_o;
        end else begin
            cmp_flag = flag_c;
        end
        cmp_flag = cmp_flag ^ cmd_q.fields.variant[VAR_INV];
    end

    // ------------------------------------------------------------------
    // Logic, shift, result mux
    // ------------------------------------------------------------------

    always_comb begin
        case (cmd_q.raw)
            CMD_AND: alu_res = op1_q & op2_q;
            CMD_OR:  alu_res = op1_q | op2_q;
            CMD_XOR: alu_res = op1_q ^ op2_q;
            default: alu_res = sum[XLEN-1:0];   // ADD / SUB
        endcase
    end

    always_comb begin
        shamt = op2_q[SHAMT_W-1:0];             // Upper op2 bits ignored
        if (!cmd_q.fields.variant[VAR_RIGHT]) begin
            shf_res = op1_q << shamt;
        end else if (cmd_q.fields.variant[VAR_ARITH]) begin
            shf_res = $signed(op1_q) >>> shamt;
        end else begin
            shf_res = op1_q >> shamt;
        end
    end

    always_comb begin
        case (cmd_q.fields.grp)
            GRP_CMP: res = XLEN'(cmp_flag);     // Zero-extended flag
            GRP_SHF: res = shf_res;
            GRP_MUL: res = '0;                  // Product built in the chain
            default: res = alu_res;
        endcase
    end

    // ------------------------------------------------------------------
    // Multiplier operands, magnitudes plus sign of product
    // ------------------------------------------------------------------

    assign is_mul  = (cmd_q.fields.grp == GRP_MUL);
    assign op1_neg = is_mul & cmd_q.fields.variant[VAR_S1] & op1_q[XLEN-1];
    assign op2_neg = is_mul & cmd_q.fields.variant[VAR_S2] & op2_q[XLEN-1];

    assign out.valid  = valid_q;
    assign out.cmd    = cmd_q;
    assign out.mcand  = op1_neg ? -op1_q : op1_q;
    assign out.mplier = is_mul ? (op2_neg ? -op2_q : op2_q) : '0;   // zero, chain adds nothing
    assign out.acc    = '0;
    assign out.neg    = op1_neg ^ op2_neg;
    assign out.res    = res;
    assign out.flag   = cmp_flag;

    // Accepted command must reach the register free of X
    a_no_x_on_accept : assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_i && ready_o) |=> !$isunknown({cmd_q, op1_q, op2_q})
    ) else $error("ialu_issue: unknown command or operand bits accepted");

endmodule

/* exec/mul_partial_stage.sv */
/* Multiplier partial-product stage
   Adds mcand times one CHUNK of the multiplier into the accumulator */
`timescale 1ns/100ps

module mul_partial_stage #(
    parameter int XLEN      = ialu_cfg_pkg::XLEN_DEFAULT,
    parameter int CHUNK     = ialu_cfg_pkg::CHUNK_DEFAULT,
    parameter int STAGE_IDX = 0
) (
    input  logic     clk,
    input  logic     rst_n,
    mul_stage_if.dst in,
    mul_stage_if.src out
);
    localparam int ACC_W = 2 * XLEN;
    localparam int POS   = STAGE_IDX * CHUNK;   // Bit weight of this stage's chunk

    logic [XLEN+CHUNK-1:0] pp;       // mcand x chunk
    logic [ACC_W-1:0]      pp_ext;   // aligned to POS

    // Stall is global, pass it upstream
    assign in.advance = out.advance;

    // ------------------------------------------------------------------
    // Partial product
    // ------------------------------------------------------------------

    assign pp     = in.mcand * in.mplier[CHUNK-1:0];
    assign pp_ext = ACC_W'(pp) << POS;

    // ------------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else if (out.advance) begin
            out.valid <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (out.advance) begin
            out.cmd    <= in.cmd;
            out.mcand  <= in.mcand;
            out.mplier <= in.mplier >> CHUNK;   // Next chunk to the bottom
            out.acc    <= in.acc + pp_ext;
            out.neg    <= in.neg;
            // Non-multiply results ride along
            out.res    <= in.res;
            out.flag   <= in.flag;
        end
    end

endmodule

/* exec/ialu_retire.sv */
/* ALU retire stage
   Sign-corrects the product, selects the result and holds it under back-pressure */
`timescale 1ns/100ps

module ialu_retire #(
    parameter int XLEN = ialu_cfg_pkg::XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    mul_stage_if.dst        in,
    output logic            valid_o,
    output logic [XLEN-1:0] res_o,
    output logic            cmp_o,
    input  logic            ready_i
);
    import ialu_cmd_pkg::*;

    logic              advance;
    logic [2*XLEN-1:0] prod;      // Signed full product
    logic [XLEN-1:0]   mul_res;
    logic [XLEN-1:0]   res_d;
    logic              cmp_d;

    // Hold everything while a result waits
    assign advance    = !(valid_o && !ready_i);
    assign in.advance = advance;

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------

    assign prod    = in.neg ? -in.acc : in.acc;
    assign mul_res = in.cmd.fields.variant[VAR_HI] ? prod[2*XLEN-1:XLEN]
                                                   : prod[XLEN-1:0];
    assign res_d   = (in.cmd.fields.grp == GRP_MUL) ? mul_res : in.res;
    assign cmp_d   = (in.cmd.fields.grp == GRP_CMP) & in.flag;   // 0 outside compares

    // ------------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
        end else if (advance) begin
            valid_o <= in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            res_o <= res_d;
            cmp_o <= cmp_d;
        end
    end

    // Stalled result stays put until taken
    a_hold_on_stall : assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_o && !ready_i) |=> (valid_o && $stable(res_o) && $stable(cmp_o))
    ) else $error("ialu_retire: result changed while stalled");

endmodule

/* rtl/ialu_top.sv */
/* Pipelined integer ALU top level
   Issue, a chain of multiplier stages and retire, joined by stage links */
`timescale 1ns/100ps

module ialu_top #(
    parameter int XLEN  = ialu_cfg_pkg::XLEN_DEFAULT,
    parameter int CHUNK = ialu_cfg_pkg::CHUNK_DEFAULT
) (
    input  logic            clk,
    input  logic            rst_n,
    // Command side
    input  logic            valid_i,
    input  logic [4:0]      cmd_i,     // raw command code
    input  logic [XLEN-1:0] op1_i,
    input  logic [XLEN-1:0] op2_i,
    output logic            ready_o,
    // Result side
    output logic            valid_o,
    output logic [XLEN-1:0] res_o,
    output logic            cmp_o,
    input  logic            ready_i
);
    import ialu_cmd_pkg::*;

    localparam int NSTAGE = XLEN / CHUNK;   // Multiplier stages

    ialu_cmd_u cmd_u;

    // link[0] from issue, link[NSTAGE] into retire
    mul_stage_if #(.XLEN(XLEN)) link [0:NSTAGE] ();

    assign cmd_u.raw = cmd_i;

    ialu_issue #(.XLEN(XLEN)) u_issue (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .cmd_i   (cmd_u),
        .op1_i   (op1_i),
        .op2_i   (op2_i),
        .ready_o (ready_o),
        .out     (link[0])
    );

    for (genvar k = 0; k < NSTAGE; k++) begin : g_stage
        mul_partial_stage #(
            .XLEN      (XLEN),
            .CHUNK     (CHUNK),
            .STAGE_IDX (k)
        ) u_stage (
            .clk   (clk),
            .rst_n (rst_n),
            .in    (link[k]),
            .out   (link[k+1])
        );
    end

    ialu_retire #(.XLEN(XLEN)) u_retire (
        .clk     (clk),
        .rst_n   (rst_n),
        .in      (link[NSTAGE]),
        .valid_o (valid_o),
        .res_o   (res_o),
        .cmp_o   (cmp_o),
        .ready_i (ready_i)
    );

endmodule

/* test/ialu_checker.sv */
/* ALU result checker
   Watches the DUT ports and compares results in order against expected values */
`timescale 1ns/100ps

module ialu_checker #(
    parameter int XLEN  = ialu_cfg_pkg::XLEN_DEFAULT,
    parameter int CHUNK = ialu_cfg_pkg::CHUNK_DEFAULT
) (
    input logic            clk,
    input logic            rst_n,
    input logic            valid_i,
    input logic            ready_o,
    input logic            valid_o,
    input logic            ready_i,
    input logic [XLEN-1:0] res_o,
    input logic            cmp_o
);
    import ialu_cfg_pkg::*;

    localparam int LATENCY = RETIRE_LATENCY + XLEN / CHUNK;   // Unstalled path

    // Expected entries, oldest first
    string           exp_name [$];
    logic [XLEN-1:0] exp_res  [$];
    logic            exp_cmp  [$];
    int unsigned     acc_cycle  [$];   // Edge of acceptance
    int unsigned     acc_stalls [$];   // Stall count at acceptance

    int unsigned     n_pass = 0;
    int unsigned     n_fail = 0;
    int unsigned     n_err  = 0;

    int unsigned     cycle  = 0;
    int unsigned     stalls = 0;
    logic            after_rst = 1'b0;   // First edge after reset checked
    logic            held = 1'b0;        // Previous edge was a stall
    logic [XLEN-1:0] res_prev;
    logic            cmp_prev;

    string           name;
    logic [XLEN-1:0] e_res;
    logic            e_cmp;
    int unsigned     lat;
    int unsigned     stl;

    task automatic expect_result(input string n, input logic [XLEN-1:0] r, input logic c);
        exp_name.push_back(n);
        exp_res.push_back(r);
        exp_cmp.push_back(c);
    endtask

    // ------------------------------------------------------------------
    // Reset state and held results
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst_n || !after_rst) begin
            if (valid_o !== 1'b0 || ready_o !== 1'b1) begin
                $display("Reset state wrong: valid_o=%b ready_o=%b", valid_o, ready_o);
                n_err++;
            end
            after_rst = rst_n;
        end
        if (held && rst_n) begin
            if (valid_o !== 1'b1 || res_o !== res_prev || cmp_o !== cmp_prev) begin
                $display("Stalled result changed or vanished before it was taken");
                n_err++;
            end
        end
        held     = rst_n && valid_o && !ready_i;
        res_prev = res_o;
        cmp_prev = cmp_o;
    end

    // ------------------------------------------------------------------
    // Transfers, in acceptance order
    // ------------------------------------------------------------------

    always @(posedge clk) begin
        if (rst_n && valid_o && ready_i) begin
            if (acc_cycle.size() == 0 || exp_name.size() == 0) begin
                $display("Result %h arrived with no test outstanding", res_o);
                n_err++;
            end else begin
                name  = exp_name.pop_front();
                e_res = exp_res.pop_front();
                e_cmp = exp_cmp.pop_front();
                lat   = cycle - acc_cycle.pop_front();
                stl   = acc_stalls.pop_front();
                if (res_o !== e_res || cmp_o !== e_cmp) begin
                    $display("Fail %s: expected res=%h cmp=%b, actual res=%h cmp=%b",
                             name, e_res, e_cmp, res_o, cmp_o);
                    n_fail++;
                end else begin
                    $display("ok   %s res=%h cmp=%b latency=%0d", name, res_o, cmp_o, lat);
                    n_pass++;
                end
                // No stall in flight, so latency is fixed
                if (stl == stalls && lat != LATENCY) begin
                    $display("Test %s took %0d cycles without any stall, %0d expected",
                             name, lat, LATENCY);
                    n_err++;
                end
            end
        end
        if (rst_n && valid_o && !ready_i) stalls++;
        if (rst_n && valid_i && ready_o) begin
            acc_cycle.push_back(cycle);
            acc_stalls.push_back(stalls);
        end
        cycle++;
    end

endmodule

/* test/ialu_tb.sv */
/* ALU testbench
   Drives commands from the input file and stalls the result side at random */
`timescale 1ns/100ps

module ialu_tb;
    import ialu_cfg_pkg::*;

    localparam int    XLEN       = XLEN_DEFAULT;
    localparam int    CHUNK      = CHUNK_DEFAULT;
    localparam int    MAX_STALL  = 3;    // Longest run of ready_i low
    localparam int    WARM_TESTS = 10;   // Issued before stalls start
    localparam string INPUT_FILE = "test/ialu_input.txt";

    logic            clk;
    logic            rst_n;
    logic            valid_i;
    logic [4:0]      cmd_i;
    logic [XLEN-1:0] op1_i;
    logic [XLEN-1:0] op2_i;
    logic            ready_o;
    logic            valid_o;
    logic [XLEN-1:0] res_o;
    logic            cmp_o;
    logic            ready_i;

    // Stimulus columns from the file
    logic [4:0]      t_cmd [$];
    logic [XLEN-1:0] t_op1 [$];
    logic [XLEN-1:0] t_op2 [$];

    int              n_tests   = 0;
    int unsigned     cycles    = 0;
    int unsigned     limit     = 0;
    logic [31:0]     rnd       = 32'd50924;   // xorshift state
    int              stall_run = 0;
    logic            stall_en  = 1'b0;

    ialu_top #(.XLEN(XLEN), .CHUNK(CHUNK)) u_ialu_top (
        .clk(clk), .rst_n(rst_n),
        .valid_i(valid_i), .cmd_i(cmd_i), .op1_i(op1_i), .op2_i(op2_i), .ready_o(ready_o),
        .valid_o(valid_o), .res_o(res_o), .cmp_o(cmp_o), .ready_i(ready_i)
    );

    ialu_checker #(.XLEN(XLEN), .CHUNK(CHUNK)) u_checker (
        .clk(clk), .rst_n(rst_n), .valid_i(valid_i), .ready_o(ready_o),
        .valid_o(valid_o), .ready_i(ready_i), .res_o(res_o), .cmp_o(cmp_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Operands stay here, name and expected values go to the checker
    task automatic read_tests(output int count);
        int              fd;
        int              n;
        string           line;
        string           name;
        logic [4:0]      code;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] res;
        logic            flag;
        count = 0;
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", INPUT_FILE);
        end else begin
            while ($fgets(line, fd) > 0) begin
                if (line.len() > 1 && line[0] != "#") begin   // Skip column notes
                    n = $sscanf(line, "%s %h %h %h %h %h", name, code, a, b, res, flag);
                    if (n == 6) begin
                        t_cmd.push_back(code);
                        t_op1.push_back(a);
                        t_op2.push_back(b);
                        u_checker.expect_result(name, res, flag);
                        count++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic print_counts();
        $display("Tests: %0d total, %0d passed, %0d failed, %0d other errors",
                 n_tests, u_checker.n_pass, u_checker.n_fail, u_checker.n_err);
    endtask

    // ------------------------------------------------------------------
    // Clock, result-side stalls, watchdog
    // ------------------------------------------------------------------

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) begin
        if (stall_en) begin
            rnd = xorshift32(rnd);
            if (rnd[2:0] < 3'd3 && stall_run < MAX_STALL) begin   // About 3 in 8
                ready_i = 1'b0;
                stall_run++;
            end else begin
                ready_i = 1'b1;
                stall_run = 0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (limit > 0 && cycles > limit) begin
                $display("Timeout: only %0d of %0d results after %0d cycles",
                         u_checker.n_pass + u_checker.n_fail, n_tests, cycles);
                print_counts();
                $display("RESULT: FAIL");
                $finish;
            end
        end
    end

    // ------------------------------------------------------------------
    // Reset and command stream
    // ------------------------------------------------------------------

    initial begin
        rst_n   = 1'b1;
        valid_i = 1'b0;
        cmd_i   = '0;
        op1_i   = '0;
        op2_i   = '0;
        ready_i = 1'b1;
        read_tests(n_tests);
        limit = n_tests * (RETIRE_LATENCY + XLEN / CHUNK + MAX_STALL) + 50;
        if (n_tests == 0) begin
            $display("No tests loaded from %s", INPUT_FILE);
            $display("RESULT: FAIL");
            $finish;
        end else begin
            #1 rst_n = 1'b0;
            repeat (8) @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < n_tests; i++) begin
                @(negedge clk);
                if (i == WARM_TESTS) stall_en <= 1'b1;   // First results unstalled
                valid_i = 1'b1;
                cmd_i   = t_cmd[i];
                op1_i   = t_op1[i];
                op2_i   = t_op2[i];
                do @(posedge clk); while (!ready_o);    // Held until accepted
            end
            @(negedge clk);
            valid_i = 1'b0;
            while (u_checker.n_pass + u_checker.n_fail < n_tests) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk);   // Room for a stray extra result
            print_counts();
            if (u_checker.n_fail == 0 && u_checker.n_err == 0) begin
                $display("RESULT: PASS");
            end else begin
                $display("RESULT: FAIL");
            end
            $finish;
        end
    end

endmodule

/* test/ialu_input.txt */
# name  cmd  op1  op2  expected_res  expected_cmp   (all hex)
# cmd is the raw 5-bit command code
add_basic   00 00000005 00000007 0000000c 0
add_wrap    00 ffffffff 00000002 00000001 0
add_ovf     00 7fffffff 00000001 80000000 0
sub_basic   01 0000000a 00000003 00000007 0
sub_neg     01 00000003 0000000a fffffff9 0
and_mix     02 f0f0f0f0 ff00ff00 f000f000 0
or_mix      03 f0f0f0f0 0f0f0000 fffff0f0 0
xor_mix     04 12345678 ffffffff edcba987 0
lt_neg      0c 80000000 00000001 00000001 1
lt_false    0c 00000001 ffffffff 00000000 0
ltu_true    08 00000001 ffffffff 00000001 1
ge_eq       0e 80000000 80000000 00000001 1
ge_false    0e 80000000 7fffffff 00000000 0
geu_true    0a ffffffff 00000000 00000001 1
geu_false   0a 00000000 80000000 00000000 0
eq_true     09 ffffffff ffffffff 00000001 1
eq_false    09 00000000 80000000 00000000 0
ne_true     0b 00000001 00000000 00000001 1
ne_false    0b 80000000 80000000 00000000 0
sll_basic   10 00000001 0000001f 80000000 0
sll_mask    10 00000003 00000024 00000030 0
srl_basic   12 80000000 00000004 08000000 0
srl_mask    12 ffffffff 00000021 7fffffff 0
sra_neg     13 80000000 00000004 f8000000 0
sra_pos     13 7fffffff 0000001f 00000000 0
sra_mask    13 f0000000 000000e3 fe000000 0
mul_basic   1b 00000007 00000006 0000002a 0
mul_neg     1b fffffffd 00000005 fffffff1 0
mul_zero    1b 00000000 ffffffff 00000000 0
mulh_neg    1f ffffffff ffffffff 00000000 0
mulh_mixed  1f 80000000 00000002 ffffffff 0
mulh_big    1f 12345678 00010000 00001234 0
mulhu_max   1c ffffffff ffffffff fffffffe 0
mulhsu_neg  1e ffffffff ffffffff ffffffff 0
mulhsu_pos  1e 00000002 80000000 00000001 0

/* vlog.f */
common/ialu_cfg_pkg.sv
common/ialu_cmd_pkg.sv
common/mul_stage_if.sv
exec/ialu_issue.sv
exec/mul_partial_stage.sv
exec/ialu_retire.sv
rtl/ialu_top.sv
test/ialu_checker.sv
test/ialu_tb.sv

/* Bender.yml */
package:
  name: ialu

sources:
  # Shared packages and the stage link
  - common/ialu_cfg_pkg.sv
  - common/ialu_cmd_pkg.sv
  - common/mul_stage_if.sv
  # Execution blocks
  - exec/ialu_issue.sv
  - exec/mul_partial_stage.sv
  - exec/ialu_retire.sv
  # Top level
  - rtl/ialu_top.sv
  # Testbench
  - target: test
    files:
      - test/ialu_checker.sv
      - test/ialu_tb.sv
